// ==== rtl/radio_core_cfg.svh ====
/*
 * radio core configuration
 * settings-bus register map, readback slots and channel count
 * for the single-daughterboard radio datapath
 */
`ifndef RADIO_CORE_CFG_SVH
`define RADIO_CORE_CFG_SVH

// two rx channels share the one radio sample
`define RC_NUM_RX_CHANNELS     2

// daughterboard registers
`define RC_SR_DB_BASE          8'd160
`define RC_DB_OFS_GPIO_OUT     8'd0
`define RC_DB_OFS_GPIO_DDR     8'd1
`define RC_DB_OFS_LEDS         8'd2
`define RC_DB_OFS_MISC_OUT     8'd3

// front-end correction settings
`define RC_SR_TX_FE_BASE       8'd208
`define RC_SR_RX_FE_BASE       8'd224
`define RC_SR_FE_CHAN_OFFSET   8'd16
`define RC_FE_SWAP_BIT         0
`define RC_FE_QNEG_BIT         1

// readback slots, one 64-bit word each
`define RC_RB_DB_BASE          8'd16
`define RC_RB_OFS_SLOT1        8'd1
`define RC_RB_OFS_SLOT2        8'd2

`endif

// ==== rtl/radio_core_pkg.sv ====
/*
 * radio core types
 * sample, settings-bus, readback and daughterboard word widths
 */
`default_nettype none

package radio_core_pkg;

   // --------------------
   // sample path
   // --------------------
   typedef logic signed [15:0] sample_t;   // one I or Q component
   typedef logic [31:0] iq_t;               // I in [31:16], Q in [15:0]

   // --------------------
   // settings bus
   // --------------------
   typedef logic [7:0]  sr_addr_t;
   typedef logic [31:0] sr_data_t;

   // --------------------
   // readback
   // --------------------
   typedef logic [7:0]  rb_addr_t;
   typedef logic [63:0] rb_data_t;

   // daughterboard side
   typedef logic [31:0] word_t;   // gpio or misc word
   typedef logic [2:0]  led_t;    // {RX, TXRX_TX, TXRX_RX}

endpackage

`default_nettype wire

// ==== rtl/radio_core_ifs.sv ====
/*
 * radio core internal interfaces
 * fe_ctrl_if carries the swap and negate controls to the correction stage,
 * db_regs_if carries the daughterboard registers to the result stage
 */
`timescale 1ns/1ps
`default_nettype none

`include "radio_core_cfg.svh"

// --------------------
// front-end controls
// --------------------
interface fe_ctrl_if ();

   logic [`RC_NUM_RX_CHANNELS-1:0] rx_iq_swap;   // one bit per rx channel
   logic [`RC_NUM_RX_CHANNELS-1:0] rx_q_neg;
   logic                           tx_iq_swap;
   logic                           tx_q_neg;

   modport decode  (output rx_iq_swap, output rx_q_neg, output tx_iq_swap, output tx_q_neg);
   modport execute (input  rx_iq_swap, input  rx_q_neg, input  tx_iq_swap, input  tx_q_neg);

endinterface

// --------------------
// daughterboard registers
// --------------------
interface db_regs_if import radio_core_pkg::*; ();

   word_t gpio_out;
   word_t gpio_ddr;
   led_t  leds;
   word_t misc_out;

   // written by the settings decoder
   modport decode (output gpio_out, output gpio_ddr, output leds, output misc_out);

   // read back and driven out by the result stage
   modport result (input gpio_out, input gpio_ddr, input leds, input misc_out);

endinterface

`default_nettype wire

// ==== rtl/settings_decode.sv ====
/*
 * settings decode
 * matches each settings-bus write against the register map and updates
 * the daughterboard registers and the per-channel front-end controls
 */
`timescale 1ns/1ps
`default_nettype none

`include "radio_core_cfg.svh"

module settings_decode import radio_core_pkg::*; (
   input  wire logic     radio_clk,
   input  wire logic     i_rst_n,
   input  wire logic     i_set_stb,
   input  wire sr_addr_t i_set_addr,
   input  wire sr_data_t i_set_data,
   fe_ctrl_if.decode     o_fe,
   db_regs_if.decode     o_db
);

   // daughterboard register addresses
   localparam sr_addr_t SR_GPIO_OUT = `RC_SR_DB_BASE + `RC_DB_OFS_GPIO_OUT;
   localparam sr_addr_t SR_GPIO_DDR = `RC_SR_DB_BASE + `RC_DB_OFS_GPIO_DDR;
   localparam sr_addr_t SR_LEDS     = `RC_SR_DB_BASE + `RC_DB_OFS_LEDS;
   localparam sr_addr_t SR_MISC_OUT = `RC_SR_DB_BASE + `RC_DB_OFS_MISC_OUT;
   localparam sr_addr_t SR_TX_FE    = `RC_SR_TX_FE_BASE;

   // --------------------
   // daughterboard regs
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_db.gpio_out <= '0;
         o_db.gpio_ddr <= '0;
         o_db.leds     <= '0;
         o_db.misc_out <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            SR_GPIO_OUT: o_db.gpio_out <= i_set_data;
            SR_GPIO_DDR: o_db.gpio_ddr <= i_set_data;
            SR_LEDS:     o_db.leds     <= i_set_data[2:0];   // only three leds on the board
            SR_MISC_OUT: o_db.misc_out <= i_set_data;
            default: ;                                       // unmapped, dropped
         endcase
      end
   end

   // --------------------
   // front-end controls
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_fe.tx_iq_swap <= 1'b0;
         o_fe.tx_q_neg   <= 1'b0;
      end else if (i_set_stb && (i_set_addr == SR_TX_FE)) begin
         o_fe.tx_iq_swap <= i_set_data[`RC_FE_SWAP_BIT];
         o_fe.tx_q_neg   <= i_set_data[`RC_FE_QNEG_BIT];
      end
   end

   // rx channel n sits at base + n * offset
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_fe.rx_iq_swap <= '0;
         o_fe.rx_q_neg   <= '0;
      end else if (i_set_stb) begin
         for (int ch = 0; ch < `RC_NUM_RX_CHANNELS; ch++) begin
            if (i_set_addr == (`RC_SR_RX_FE_BASE + sr_addr_t'(ch) * `RC_SR_FE_CHAN_OFFSET)) begin
               o_fe.rx_iq_swap[ch] <= i_set_data[`RC_FE_SWAP_BIT];
               o_fe.rx_q_neg[ch]   <= i_set_data[`RC_FE_QNEG_BIT];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/fe_execute.sv ====
/*
 * front-end correction
 * per channel: optional I/Q swap, then optional Q negation with
 * saturation, one register stage for rx, tx and the rx strobe
 */
`timescale 1ns/1ps
`default_nettype none

`include "radio_core_cfg.svh"

module fe_execute import radio_core_pkg::*; (
   input  wire logic  radio_clk,
   input  wire logic  i_rst_n,
   fe_ctrl_if.execute i_fe,
   input  wire iq_t   i_rx_data,
   input  wire logic  i_rx_stb,
   input  wire iq_t   i_tx_data,
   output iq_t        o_rx_corr [`RC_NUM_RX_CHANNELS],
   output logic       o_rx_corr_stb,
   output iq_t        o_tx_corr
);

   localparam sample_t SAMPLE_MIN = 16'sh8000;
   localparam sample_t SAMPLE_MAX = 16'sh7fff;

   // --------------------
   // correction function
   // --------------------
   // swap first, negate the resulting Q second
   function automatic iq_t fe_correct(
      input iq_t  din,
      input logic swap,
      input logic qneg
   );
      sample_t i_s;
      sample_t q_s;

      i_s = swap ? din[15:0]  : din[31:16];
      q_s = swap ? din[31:16] : din[15:0];
      if (qneg) begin
         // -(-32768) does not fit, clamp to full scale
         q_s = (q_s == SAMPLE_MIN) ? SAMPLE_MAX : -q_s;
      end
      return {i_s, q_s};
   endfunction

   // --------------------
   // rx channels
   // --------------------
   // every channel sees the same radio sample
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         for (int ch = 0; ch < `RC_NUM_RX_CHANNELS; ch++) begin
            o_rx_corr[ch] <= '0;
         end
         o_rx_corr_stb <= 1'b0;
      end else begin
         for (int ch = 0; ch < `RC_NUM_RX_CHANNELS; ch++) begin
            o_rx_corr[ch] <= fe_correct(i_rx_data, i_fe.rx_iq_swap[ch], i_fe.rx_q_neg[ch]);
         end
         o_rx_corr_stb <= i_rx_stb;   // follows the data stage
      end
   end

   // --------------------
   // tx channel
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_tx_corr <= '0;
      end else begin
         o_tx_corr <= fe_correct(i_tx_data, i_fe.tx_iq_swap, i_fe.tx_q_neg);
      end
   end

endmodule

`default_nettype wire

// ==== rtl/radio_result.sv ====
/*
 * result stage
 * baseband override and output registers for the rx/tx samples,
 * misc input capture and the registered 64-bit readback mux
 */
`timescale 1ns/1ps
`default_nettype none

`include "radio_core_cfg.svh"

module radio_result import radio_core_pkg::*; (
   input  wire logic     radio_clk,
   input  wire logic     i_rst_n,
   db_regs_if.result     i_db,
   input  wire iq_t      i_rx_corr [`RC_NUM_RX_CHANNELS],
   input  wire logic     i_rx_corr_stb,
   input  wire iq_t      i_tx_corr,
   input  wire logic     i_bb_valid,
   input  wire iq_t      i_bb_data,
   input  wire word_t    i_misc_in,
   input  wire word_t    i_db_gpio_in,
   input  wire rb_addr_t i_rb_addr,
   output iq_t           o_rx_data0,
   output iq_t           o_rx_data1,
   output logic          o_rx_stb,
   output iq_t           o_tx_data,
   output rb_data_t      o_rb_data
);

   localparam rb_addr_t RB_SLOT0 = `RC_RB_DB_BASE;
   localparam rb_addr_t RB_SLOT1 = `RC_RB_DB_BASE + `RC_RB_OFS_SLOT1;
   localparam rb_addr_t RB_SLOT2 = `RC_RB_DB_BASE + `RC_RB_OFS_SLOT2;

   iq_t   rx_q [`RC_NUM_RX_CHANNELS];
   word_t misc_in_q;   // misc input, one cycle old

   // --------------------
   // sample outputs
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         for (int ch = 0; ch < `RC_NUM_RX_CHANNELS; ch++) begin
            rx_q[ch] <= '0;
         end
         o_rx_stb  <= 1'b0;
         o_tx_data <= '0;
      end else begin
         for (int ch = 0; ch < `RC_NUM_RX_CHANNELS; ch++) begin
            rx_q[ch] <= i_bb_valid ? i_bb_data : i_rx_corr[ch];   // baseband wins
         end
         o_rx_stb  <= i_rx_corr_stb;   // strobe not touched by override
         o_tx_data <= i_tx_corr;
      end
   end

   assign o_rx_data0 = rx_q[0];
   assign o_rx_data1 = rx_q[1];

   // --------------------
   // misc capture, readback
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         misc_in_q <= '0;
         o_rb_data <= '0;
      end else begin
         misc_in_q <= i_misc_in;
         case (i_rb_addr)
            RB_SLOT0: o_rb_data <= {misc_in_q, i_db_gpio_in};
            RB_SLOT1: o_rb_data <= {i_db.gpio_ddr, i_db.gpio_out};
            RB_SLOT2: o_rb_data <= {word_t'(i_db.leds), i_db.misc_out};
            default:  o_rb_data <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/radio_core_top.sv ====
/*
 * radio core top level
 * single daughterboard, two rx channels and one tx channel:
 * settings decode, front-end correction and result stage
 */
`timescale 1ns/1ps
`default_nettype none

`include "radio_core_cfg.svh"

module radio_core_top import radio_core_pkg::*; (
   input  wire logic     radio_clk,
   input  wire logic     i_rst_n,
   // settings bus
   input  wire logic     i_set_stb,
   input  wire sr_addr_t i_set_addr,
   input  wire sr_data_t i_set_data,
   // radio samples
   input  wire iq_t      i_rx_data,
   input  wire logic     i_rx_stb,
   input  wire iq_t      i_tx_data,
   // baseband override
   input  wire logic     i_bb_valid,
   input  wire iq_t      i_bb_data,
   // daughterboard inputs, readback
   input  wire word_t    i_misc_in,
   input  wire word_t    i_db_gpio_in,
   input  wire rb_addr_t i_rb_addr,
   output iq_t           o_rx_data0,
   output iq_t           o_rx_data1,
   output logic          o_rx_stb,
   output iq_t           o_tx_data,
   output word_t         o_db_gpio_out,
   output word_t         o_db_gpio_ddr,
   output led_t          o_radio_led,
   output word_t         o_misc_out,
   output rb_data_t      o_rb_data
);

   fe_ctrl_if fe_bus ();
   db_regs_if db_bus ();

   iq_t  rx_corr [`RC_NUM_RX_CHANNELS];
   logic rx_corr_stb;
   iq_t  tx_corr;

   // --------------------
   // decode
   // --------------------
   settings_decode u_decode (
      .radio_clk (radio_clk), .i_rst_n (i_rst_n),
      .i_set_stb (i_set_stb), .i_set_addr (i_set_addr), .i_set_data (i_set_data),
      .o_fe      (fe_bus.decode),
      .o_db      (db_bus.decode)
   );

   // --------------------
   // execute
   // --------------------
   fe_execute u_execute (
      .radio_clk (radio_clk), .i_rst_n (i_rst_n),
      .i_fe      (fe_bus.execute),
      .i_rx_data (i_rx_data), .i_rx_stb (i_rx_stb), .i_tx_data (i_tx_data),
      .o_rx_corr (rx_corr), .o_rx_corr_stb (rx_corr_stb), .o_tx_corr (tx_corr)
   );

   // --------------------
   // result
   // --------------------
   radio_result u_result (
      .radio_clk     (radio_clk), .i_rst_n (i_rst_n),
      .i_db          (db_bus.result),
      .i_rx_corr     (rx_corr), .i_rx_corr_stb (rx_corr_stb), .i_tx_corr (tx_corr),
      .i_bb_valid    (i_bb_valid), .i_bb_data (i_bb_data),
      .i_misc_in     (i_misc_in), .i_db_gpio_in (i_db_gpio_in), .i_rb_addr (i_rb_addr),
      .o_rx_data0    (o_rx_data0), .o_rx_data1 (o_rx_data1), .o_rx_stb (o_rx_stb),
      .o_tx_data     (o_tx_data), .o_rb_data (o_rb_data)
   );

   // daughterboard pins straight from the register file
   assign o_db_gpio_out = db_bus.gpio_out;
   assign o_db_gpio_ddr = db_bus.gpio_ddr;
   assign o_radio_led   = db_bus.leds;
   assign o_misc_out    = db_bus.misc_out;

endmodule

`default_nettype wire

// ==== sim/radio_core_properties.sv ====
/*
 * radio core properties
 * concurrent checks bound onto the top level: rx strobe under reset,
 * rx strobe latency and the width of the led readback slot
 */
`timescale 1ns/1ps
`default_nettype none

`include "radio_core_cfg.svh"

module radio_core_properties import radio_core_pkg::*; (
   input wire logic     radio_clk,
   input wire logic     i_rst_n,
   input wire logic     i_rx_stb,
   input wire logic     o_rx_stb,
   input wire rb_addr_t i_rb_addr,
   input wire rb_data_t o_rb_data
);

   localparam rb_addr_t RB_LEDS = `RC_RB_DB_BASE + `RC_RB_OFS_SLOT2;

   int assert_fails = 0;   // failed assertions so far

   // sync reset clears the strobe on the following edge
   a_stb_reset: assert property (@(posedge radio_clk) !i_rst_n |=> !o_rx_stb)
      else begin
         $error("o_rx_stb high after a reset cycle");
         assert_fails++;
      end

   // two register stages, execute then result
   a_stb_latency: assert property (@(posedge radio_clk)
      ($past(i_rst_n, 2) && $past(i_rst_n)) |-> (o_rx_stb == $past(i_rx_stb, 2)))
      else begin
         $error("o_rx_stb does not follow i_rx_stb by two cycles");
         assert_fails++;
      end

   a_led_upper: assert property (@(posedge radio_clk)
      ($past(i_rb_addr) == RB_LEDS) |-> (o_rb_data[63:35] == '0))   // only 3 led bits
      else begin
         $error("led readback slot has bits set above the led field");
         assert_fails++;
      end

endmodule

`default_nettype wire

// ==== sim/radio_core_tb.sv ====
/*
 * radio core testbench
 * LCG stimulus against a cycle model of the register map and the
 * two-stage sample pipeline, all outputs compared after every edge
 */
`timescale 1ns/1ps
`default_nettype none

`include "radio_core_cfg.svh"

module radio_core_tb import radio_core_pkg::*; ();

   localparam int RESET_CYCLES   = 16;
   localparam int TEST_CYCLES    = 300;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + 5 * TEST_CYCLES + 20;   // all tests plus margin
   localparam sr_addr_t SR_GPIO_OUT = `RC_SR_DB_BASE + `RC_DB_OFS_GPIO_OUT;
   localparam sr_addr_t SR_RX_FE0   = `RC_SR_RX_FE_BASE;
   localparam sr_addr_t SR_RX_FE1   = `RC_SR_RX_FE_BASE + `RC_SR_FE_CHAN_OFFSET;
   localparam rb_addr_t RB_SLOT0    = `RC_RB_DB_BASE;

   logic     radio_clk, i_rst_n, i_set_stb, i_rx_stb, i_bb_valid, o_rx_stb;
   sr_addr_t i_set_addr;
   sr_data_t i_set_data;
   rb_addr_t i_rb_addr;
   iq_t      i_rx_data, i_tx_data, i_bb_data, o_rx_data0, o_rx_data1, o_tx_data;
   word_t    i_misc_in, i_db_gpio_in, o_db_gpio_out, o_db_gpio_ddr, o_misc_out;
   led_t     o_radio_led;
   rb_data_t o_rb_data;

   // model state
   word_t    m_gpio_out, m_gpio_ddr, m_misc_out, m_misc_q;
   led_t     m_leds;
   logic [`RC_NUM_RX_CHANNELS-1:0] m_rx_swap, m_rx_neg;
   logic     m_tx_swap, m_tx_neg, m_s1_stb, m_rx_stb;
   iq_t      m_s1_rx [`RC_NUM_RX_CHANNELS];
   iq_t      m_rx_out [`RC_NUM_RX_CHANNELS];
   iq_t      m_s1_tx, m_tx_out;
   rb_data_t m_rb;

   logic [31:0] lcg_state;
   int errors = 0;
   int checks_done = 0;
   int cycle_count = 0;

   radio_core_top i_dut (.*);

   bind radio_core_top radio_core_properties u_props (
      .radio_clk (radio_clk), .i_rst_n (i_rst_n), .i_rx_stb (i_rx_stb),
      .o_rx_stb (o_rx_stb), .i_rb_addr (i_rb_addr), .o_rb_data (o_rb_data)
   );

   initial radio_clk = 1'b0;
   always #2 radio_clk = ~radio_clk;   // 4 ns period

   always @(posedge radio_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // --------------------
   // reference model
   // --------------------
   function automatic iq_t expected_fe(input iq_t din, input logic swap, input logic neg);
      int i_val;
      int q_val;
      i_val = swap ? int'($signed(din[15:0])) : int'($signed(din[31:16]));
      q_val = swap ? int'($signed(din[31:16])) : int'($signed(din[15:0]));
      if (neg) begin
         q_val = (-q_val > 32767) ? 32767 : -q_val;   // only -32768 overflows
      end
      return {i_val[15:0], q_val[15:0]};
   endfunction

   function automatic rb_data_t expected_rb(input rb_addr_t addr);
      rb_data_t res;
      case (addr)
         RB_SLOT0:                    res = {m_misc_q, i_db_gpio_in};
         RB_SLOT0 + `RC_RB_OFS_SLOT1: res = {m_gpio_ddr, m_gpio_out};
         RB_SLOT0 + `RC_RB_OFS_SLOT2: res = {29'd0, m_leds, m_misc_out};
         default:                     res = '0;
      endcase
      return res;
   endfunction

   task automatic reset_model();
      {m_gpio_out, m_gpio_ddr, m_misc_out, m_misc_q, m_leds} = '0;
      {m_rx_swap, m_rx_neg, m_tx_swap, m_tx_neg, m_s1_stb, m_rx_stb} = '0;
      {m_s1_tx, m_tx_out, m_rb} = '0;
      for (int ch = 0; ch < `RC_NUM_RX_CHANNELS; ch++) begin
         m_s1_rx[ch]  = '0;
         m_rx_out[ch] = '0;
      end
   endtask

   task automatic apply_write(input sr_addr_t addr, input sr_data_t data);
      case (addr)
         SR_GPIO_OUT:                          m_gpio_out = data;
         `RC_SR_DB_BASE + `RC_DB_OFS_GPIO_DDR: m_gpio_ddr = data;
         `RC_SR_DB_BASE + `RC_DB_OFS_LEDS:     m_leds     = data[2:0];
         `RC_SR_DB_BASE + `RC_DB_OFS_MISC_OUT: m_misc_out = data;
         `RC_SR_TX_FE_BASE: begin
            m_tx_swap = data[`RC_FE_SWAP_BIT];
            m_tx_neg  = data[`RC_FE_QNEG_BIT];
         end
         default: ;
      endcase
      for (int ch = 0; ch < `RC_NUM_RX_CHANNELS; ch++) begin
         if (addr == sr_addr_t'(`RC_SR_RX_FE_BASE + ch * `RC_SR_FE_CHAN_OFFSET)) begin
            m_rx_swap[ch] = data[`RC_FE_SWAP_BIT];
            m_rx_neg[ch]  = data[`RC_FE_QNEG_BIT];
         end
      end
   endtask

   // one clock edge, later stages first so each reads the old state
   task automatic model_edge();
      if (!i_rst_n) begin
         reset_model();
      end else begin
         for (int ch = 0; ch < `RC_NUM_RX_CHANNELS; ch++) begin
            m_rx_out[ch] = i_bb_valid ? i_bb_data : m_s1_rx[ch];
            m_s1_rx[ch]  = expected_fe(i_rx_data, m_rx_swap[ch], m_rx_neg[ch]);
         end
         m_rx_stb = m_s1_stb;
         m_s1_stb = i_rx_stb;
         m_tx_out = m_s1_tx;
         m_s1_tx  = expected_fe(i_tx_data, m_tx_swap, m_tx_neg);
         m_rb     = expected_rb(i_rb_addr);
         m_misc_q = i_misc_in;
         if (i_set_stb) begin
            apply_write(i_set_addr, i_set_data);
         end
      end
   endtask

   // --------------------
   // checks
   // --------------------
   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
      checks_done++;
      if (got !== expected) begin
         errors++;
         $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
      end
   endtask

   task automatic check_outputs();
      check_value("o_rx_data0", 64'(o_rx_data0), 64'(m_rx_out[0]));
      check_value("o_rx_data1", 64'(o_rx_data1), 64'(m_rx_out[1]));
      check_value("o_rx_stb", 64'(o_rx_stb), 64'(m_rx_stb));
      check_value("o_tx_data", 64'(o_tx_data), 64'(m_tx_out));
      check_value("o_db_gpio_out", 64'(o_db_gpio_out), 64'(m_gpio_out));
      check_value("o_db_gpio_ddr", 64'(o_db_gpio_ddr), 64'(m_gpio_ddr));
      check_value("o_radio_led", 64'(o_radio_led), 64'(m_leds));
      check_value("o_misc_out", 64'(o_misc_out), 64'(m_misc_out));
      check_value("o_rb_data", o_rb_data, m_rb);
   endtask

   // --------------------
   // stimulus
   // --------------------
   task automatic drive_idle();
      {i_set_stb, i_rx_stb, i_bb_valid, i_set_addr, i_rb_addr} = '0;
      {i_set_data, i_rx_data, i_tx_data, i_bb_data, i_misc_in, i_db_gpio_in} = '0;
   endtask

   task automatic drive_random(input int test_num);
      logic [31:0] r;
      r            = next_rand();
      i_set_data   = next_rand();
      i_rx_data    = next_rand();
      i_tx_data    = next_rand();
      i_bb_data    = next_rand();
      i_misc_in    = next_rand();
      i_db_gpio_in = next_rand();
      i_rx_stb     = r[0];
      i_bb_valid   = (test_num == 4) && r[1];
      i_rb_addr    = (test_num == 6 && r[2]) ? RB_SLOT0 + rb_addr_t'(r[4:3])
                                             : rb_addr_t'(r[31:24]);
      // full-scale negative components hit the saturation case
      if (r[6:5] == 2'b00)
         i_rx_data[15:0] = 16'h8000;
      if (r[8:7] == 2'b00)
         i_rx_data[31:16] = 16'h8000;
      if (r[10:9] == 2'b00)
         i_tx_data[15:0] = 16'h8000;
      if (r[12:11] == 2'b00)
         i_tx_data[31:16] = 16'h8000;
      case (test_num)
         2: begin
            i_set_stb  = r[13] | r[14];
            i_set_addr = r[15] ? SR_GPIO_OUT + sr_addr_t'(r[17:16]) : sr_addr_t'(r[23:16]);
         end
         3, 4: begin
            i_set_stb  = r[13] & r[14];   // hold settings a few samples
            i_set_addr = r[15] ? SR_RX_FE1 : SR_RX_FE0;
         end
         5: begin
            i_set_stb  = r[13] & r[14];
            i_set_addr = `RC_SR_TX_FE_BASE;
         end
         default: begin
            i_set_stb  = r[13];
            i_set_addr = SR_GPIO_OUT + sr_addr_t'(r[17:16]);
         end
      endcase
   endtask

   task automatic run_test(input int test_num, input string name, input int cycles);
      int errs_before;
      errs_before = errors;
      for (int k = 0; k < cycles; k++) begin
         @(posedge radio_clk);
         model_edge();
         #1;
         check_outputs();
         drive_random(test_num);   // busy inputs under reset too
      end
      $display("test %0d %s: %0d mismatches", test_num, name, errors - errs_before);
   endtask

   initial begin
      lcg_state = 32'h93db_a5c9;
      i_rst_n   = 1'b0;
      drive_idle();
      reset_model();
      run_test(1, "reset state", RESET_CYCLES);
      i_rst_n = 1'b1;
      run_test(2, "register writes", TEST_CYCLES);
      run_test(3, "receive correction", TEST_CYCLES);
      run_test(4, "baseband override", TEST_CYCLES);
      run_test(5, "transmit correction", TEST_CYCLES);
      run_test(6, "readback", TEST_CYCLES);
      $display("%0d checks, %0d mismatches, %0d assertion failures",
               checks_done, errors, i_dut.u_props.assert_fails);
      if (errors == 0 && i_dut.u_props.assert_fails == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== radio_core.f ====
+incdir+rtl
rtl/radio_core_pkg.sv
rtl/radio_core_ifs.sv
rtl/settings_decode.sv
rtl/fe_execute.sv
rtl/radio_result.sv
rtl/radio_core_top.sv
sim/radio_core_properties.sv
sim/radio_core_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the radio core

VERILATOR  := verilator
TOP        := radio_core_tb
DUT_TOP    := radio_core_top
FILELIST   := radio_core.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ALL CHECKS PASSED
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)
RUN_ARGS   := +verilator+error+limit+1000
SOURCES    := $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
